//--- filelist.f
+incdir+hdl
hdl/corePkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/loadStoreUnit.sv
hdl/memArbiter.sv
hdl/rvCore.sv
verif/tbRvCore.sv

//--- hdl/alu.sv
/* integer ALU and branch comparator of the execute stage
   result follows op, branchTaken follows the branch funct3 on the same operands */
`timescale 1ns/1ns

module alu (
	input corePkg::aluOpT op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [2:0] funct3,
	output logic [31:0] result,
	output logic branchTaken
);

	always_comb begin
		case (op)
			corePkg::opAdd: result = a + b;
			corePkg::opSub: result = a - b;
			// shift amount is the low five bits only
			corePkg::opSll: result = a << b[4:0];
			corePkg::opSlt: result = {31'd0, $signed(a) < $signed(b)};
			corePkg::opSltu: result = {31'd0, a < b};
			corePkg::opXor: result = a ^ b;
			corePkg::opSrl: result = a >> b[4:0];
			corePkg::opSra: result = $unsigned($signed(a) >>> b[4:0]);
			corePkg::opOr: result = a | b;
			corePkg::opAnd: result = a & b;
			default: result = b;
		endcase
	end

	// BEQ BNE BLT BGE BLTU BGEU, 010 and 011 are not branches
	always_comb begin
		case (funct3)
			3'b000: branchTaken = (a == b);
			3'b001: branchTaken = (a != b);
			3'b100: branchTaken = ($signed(a) < $signed(b));
			3'b101: branchTaken = ($signed(a) >= $signed(b));
			3'b110: branchTaken = (a < b);
			3'b111: branchTaken = (a >= b);
			default: branchTaken = 1'b0;
		endcase
	end

	// known op and operands must give a known result
	always_comb begin
		if (!$isunknown({op, a, b})) begin
			assert (!$isunknown(result)) else $error("alu result unknown for op %0d", op);
		end
	end

endmodule

//--- hdl/coreCfg.svh
/* design-wide constants for the rvCore integer core and its testbench
   include wherever the reset PC, memory size or test-end address is needed */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// word-address bits decoded by the memory model, 1024 words or 4 KiB
`define ADDR_BITS 10

// a store to this address marks the end of a test program
`define DONE_ADDR 32'h0000_0FFC

`endif

//--- hdl/corePkg.sv
/* shared types for the rvCore pipeline: ALU ops, decoded control,
   pipeline registers and the memory bus request */
package corePkg;

	// ALU operation set, passB carries the LUI immediate through
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opSll,
		opSlt,
		opSltu,
		opXor,
		opSrl,
		opSra,
		opOr,
		opAnd,
		opPassB
	} aluOpT;

	// decoded control for one instruction
	typedef struct packed {
		aluOpT aluOp;
		// B operand from the immediate instead of rs2
		logic aluSrcImm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic [2:0] funct3;
		logic isBranch;
		logic isJal;
		logic isJalr;
		logic isAuipc;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} ctrlT;

	// fetch to execute register
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} exStageT;

	// execute to memory/writeback register
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		// ALU result, or the effective address for loads and stores
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [31:0] pcPlus4;
	} memStageT;

	// single-cycle bus request, read data comes back combinationally
	typedef struct packed {
		logic valid;
		logic we;
		logic [3:0] byteEn;
		logic [31:0] addr;
		logic [31:0] wdata;
	} memReqT;

endpackage

//--- hdl/instrDecoder.sv
/* RV32I decoder for the execute stage
   produces the control struct and the sign-extended immediate of one instruction */
`timescale 1ns/1ns

module instrDecoder (
	input logic [31:0] instr,
	output corePkg::ctrlT ctrl,
	output logic [31:0] imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	// funct7 bit 5, the sub / arithmetic-shift modifier
	logic modBit;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign modBit = instr[30];

	// funct3 plus modifier to ALU op, shared by register and immediate forms
	function automatic corePkg::aluOpT aluOpFor(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000: aluOpFor = sub ? corePkg::opSub : corePkg::opAdd;
			3'b001: aluOpFor = corePkg::opSll;
			3'b010: aluOpFor = corePkg::opSlt;
			3'b011: aluOpFor = corePkg::opSltu;
			3'b100: aluOpFor = corePkg::opXor;
			3'b101: aluOpFor = sub ? corePkg::opSra : corePkg::opSrl;
			3'b110: aluOpFor = corePkg::opOr;
			default: aluOpFor = corePkg::opAnd;
		endcase
	endfunction

	always_comb begin
		// anything not matched below stays a no-op with all writes off
		ctrl = '0;
		ctrl.aluOp = corePkg::opAdd;
		ctrl.funct3 = funct3;
		ctrl.rd = instr[11:7];
		ctrl.rs1 = instr[19:15];
		ctrl.rs2 = instr[24:20];
		imm = {{20{instr[31]}}, instr[31:20]};
		case (opcode)
			7'b0110011: begin
				ctrl.aluOp = aluOpFor(funct3, modBit);
				ctrl.regWrite = 1'b1;
			end
			7'b0010011: begin
				// no SUBI, modifier only counts for SRAI
				ctrl.aluOp = aluOpFor(funct3, modBit && funct3 == 3'b101);
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			7'b0000011: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			7'b0100011: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			7'b1100011: begin
				// compare on rs1 / rs2, target comes from pc + imm
				ctrl.isBranch = 1'b1;
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			7'b0110111: begin
				ctrl.aluOp = corePkg::opPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = {instr[31:12], 12'b0};
			end
			7'b0010111: begin
				ctrl.isAuipc = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = {instr[31:12], 12'b0};
			end
			7'b1101111: begin
				ctrl.isJal = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			7'b1100111: begin
				// ALU forms rs1 + imm, bit 0 cleared at the top level
				ctrl.isJalr = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl.rd = 5'd0;
		endcase
	end

endmodule

//--- hdl/loadStoreUnit.sv
/* memory-stage data path between the core and the bus
   builds byte-enabled store requests and extracts extended load data */
`timescale 1ns/1ns

module loadStoreUnit (
	input corePkg::ctrlT ctrl,
	input logic [31:0] addr,
	input logic [31:0] storeData,
	input logic [31:0] memRdata,
	output corePkg::memReqT req,
	output logic [31:0] loadData
);

	// addressed lane moved down to bit 0
	logic [31:0] laneData;

	assign laneData = memRdata >> {addr[1:0], 3'b000};

	always_comb begin
		req.valid = ctrl.memRead || ctrl.memWrite;
		req.we = ctrl.memWrite;
		// word address, the lanes are chosen by byteEn
		req.addr = {addr[31:2], 2'b00};
		case (ctrl.funct3[1:0])
			2'b00: begin
				req.wdata = {4{storeData[7:0]}};
				req.byteEn = 4'b0001 << addr[1:0];
			end
			2'b01: begin
				req.wdata = {2{storeData[15:0]}};
				req.byteEn = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				req.wdata = storeData;
				req.byteEn = 4'b1111;
			end
		endcase
	end

	// funct3[2] picks zero extension for LBU / LHU
	always_comb begin
		case (ctrl.funct3)
			3'b000: loadData = {{24{laneData[7]}}, laneData[7:0]};
			3'b001: loadData = {{16{laneData[15]}}, laneData[15:0]};
			3'b100: loadData = {24'd0, laneData[7:0]};
			3'b101: loadData = {16'd0, laneData[15:0]};
			default: loadData = memRdata;
		endcase
	end

	// no misaligned traps, so flag them here instead
	always_comb begin
		if (req.valid && ctrl.funct3[1:0] == 2'b01) begin
			assert (!addr[0]) else $error("halfword access at odd address %h", addr);
		end
		if (req.valid && ctrl.funct3[1:0] == 2'b10) begin
			assert (addr[1:0] == 2'b00) else $error("word access at unaligned address %h", addr);
		end
	end

endmodule

//--- hdl/memArbiter.sv
/* fixed-priority arbiter for the single external memory bus
   data accesses win, fetch gets a word read otherwise and is told to stall */
`timescale 1ns/1ns

module memArbiter (
	input logic [31:0] fetchAddr,
	input corePkg::memReqT dataReq,
	output corePkg::memReqT memReq,
	output logic fetchStall
);

	// fetch loses the bus for the whole cycle a load or store is out
	assign fetchStall = dataReq.valid;

	always_comb begin
		if (dataReq.valid) begin
			memReq = dataReq;
		end else begin
			// instruction fetch is always a full-word read
			memReq.valid = 1'b1;
			memReq.we = 1'b0;
			memReq.byteEn = 4'b1111;
			memReq.addr = fetchAddr;
			memReq.wdata = 32'd0;
		end
	end

	// the bus is never idle, one side always owns it
	always_comb begin
		if (!$isunknown(dataReq.valid)) begin
			assert (memReq.valid) else $error("memory bus left without a request");
		end
	end

endmodule

//--- hdl/regFile.sv
/* integer register file, x1 to x31 in storage and x0 tied to zero
   two combinational read ports, one write port on the rising clock edge */
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic we,
	input logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [1:31];

	// same-cycle write/read is covered by forwarding in the core
	always_ff @(posedge clk) begin
		if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 never reaches the array
	assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

//--- hdl/rvCore.sv
/* three-stage RV32I core: fetch, execute, memory/writeback
   one external bus shared by fetch and data through memArbiter */
`timescale 1ns/1ns
`include "coreCfg.svh"

module rvCore (
	input logic clk,
	input logic rstN,
	output corePkg::memReqT memReq,
	input logic [31:0] memRdata
);

	logic [31:0] pc;
	corePkg::exStageT exStage;
	corePkg::memStageT memStage;

	// execute stage nets
	corePkg::ctrlT exCtrl;
	logic [31:0] imm;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic [31:0] fwdA;
	logic [31:0] fwdB;
	logic [31:0] aluResult;
	logic [31:0] exResult;
	logic [31:0] pcPlusImm;
	logic branchCond;
	logic redirect;
	logic [31:0] redirectPc;

	// memory/writeback nets
	corePkg::ctrlT memCtrl;
	corePkg::memReqT dataReq;
	logic [31:0] loadData;
	logic [31:0] wbData;
	logic fetchStall;

	instrDecoder decoder (
		.instr(exStage.instr),
		.ctrl(exCtrl),
		.imm(imm)
	);

	// written from memory/writeback, read in execute
	regFile regs (
		.clk(clk),
		.rs1(exCtrl.rs1),
		.rs2(exCtrl.rs2),
		.rd(memCtrl.rd),
		.we(memCtrl.regWrite),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// bypass from the instruction one stage ahead, x0 never forwarded
	assign fwdA = (memCtrl.regWrite && memCtrl.rd != 5'd0 && memCtrl.rd == exCtrl.rs1) ?
		wbData : rdata1;
	assign fwdB = (memCtrl.regWrite && memCtrl.rd != 5'd0 && memCtrl.rd == exCtrl.rs2) ?
		wbData : rdata2;

	alu exAlu (
		.op(exCtrl.aluOp),
		.a(fwdA),
		.b(exCtrl.aluSrcImm ? imm : fwdB),
		.funct3(exCtrl.funct3),
		.result(aluResult),
		.branchTaken(branchCond)
	);

	// one adder for branch, JAL and AUIPC
	assign pcPlusImm = exStage.pc + imm;
	assign exResult = exCtrl.isAuipc ? pcPlusImm : aluResult;

	// resolve control flow in execute, a bubble slot has no effect
	assign redirect = exStage.valid &&
		(exCtrl.isJal || exCtrl.isJalr || (exCtrl.isBranch && branchCond));
	assign redirectPc = exCtrl.isJalr ? {aluResult[31:1], 1'b0} : pcPlusImm;

	// memory-stage control with every side effect qualified by valid
	always_comb begin
		memCtrl = memStage.ctrl;
		memCtrl.regWrite = memStage.valid && memStage.ctrl.regWrite;
		memCtrl.memRead = memStage.valid && memStage.ctrl.memRead;
		memCtrl.memWrite = memStage.valid && memStage.ctrl.memWrite;
	end

	loadStoreUnit lsu (
		.ctrl(memCtrl),
		.addr(memStage.aluResult),
		.storeData(memStage.storeData),
		.memRdata(memRdata),
		.req(dataReq),
		.loadData(loadData)
	);

	memArbiter arbiter (
		.fetchAddr(pc),
		.dataReq(dataReq),
		.memReq(memReq),
		.fetchStall(fetchStall)
	);

	// writeback pick: load data, link value or ALU result
	always_comb begin
		if (memCtrl.memRead) begin
			wbData = loadData;
		end else if (memCtrl.isJal || memCtrl.isJalr) begin
			wbData = memStage.pcPlus4;
		end else begin
			wbData = memStage.aluResult;
		end
	end

	// pc holds while the data side owns the bus, a redirect still wins
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (!fetchStall) begin
			pc <= pc + 32'd4;
		end
	end

	// fetched word dropped on a stall or after a taken branch
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exStage.valid <= 1'b0;
		end else begin
			exStage.valid <= !fetchStall && !redirect;
			exStage.pc <= pc;
			exStage.instr <= memRdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memStage.valid <= 1'b0;
		end else begin
			memStage.valid <= exStage.valid;
			memStage.ctrl <= exCtrl;
			memStage.aluResult <= exResult;
			memStage.storeData <= fwdB;
			memStage.pcPlus4 <= exStage.pc + 32'd4;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build the rvCore testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbRvCore -f filelist.f -o simRvCore

# the simulator exit status is not trusted, the log decides
./obj_dir/simRvCore > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
	exit 1
fi

//--- verif/tbRvCore.sv
/* directed testbench for rvCore with a byte-enabled single-cycle memory model
   each test assembles a program, runs it up to the done store and checks scratch words */
`timescale 1ns/1ns
`include "coreCfg.svh"

module tbRvCore;

	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	// scratch region starts at byte 0x800, x31 points there
	localparam int scratchWord = 512;
	localparam int runLimit = 4000;

	logic clk;
	logic rstN;
	corePkg::memReqT memReq;
	logic [31:0] memRdata;

	// live memory and the program image copied in during reset
	logic [31:0] mem [0:1023];
	logic [31:0] image [0:1023];

	int emitPtr;
	int slotPtr;
	int expSlot[$];
	logic [31:0] expWord[$];
	logic [31:0] storeLog[$];
	integer seed;
	int failCount;

	rvCore UUT (
		.clk(clk),
		.rstN(rstN),
		.memReq(memReq),
		.memRdata(memRdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// read data follows the request address in the same cycle
	assign memRdata = mem[memReq.addr[`ADDR_BITS+1:2]];

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 1024; i++) begin
				mem[i] <= image[i];
			end
		end else if (memReq.valid && memReq.we) begin
			for (int b = 0; b < 4; b++) begin
				if (memReq.byteEn[b]) begin
					mem[memReq.addr[`ADDR_BITS+1:2]][8*b +: 8] <= memReq.wdata[8*b +: 8];
				end
			end
		end
	end

	// untouched words carry their own index twice
	function automatic logic [31:0] fillWord(input int idx);
		logic [9:0] a;
		a = idx[9:0];
		return {6'h2a, a, 6'h15, a};
	endfunction

	// instruction formats
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// expected results by the RV32I rules
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				// arithmetic shift fills the vacated top bits with the sign
				if (alt && a[31]) begin
					return (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]);
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic checkEqual(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			failCount++;
			$display("ERROR: %s got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic failRun(input string why);
		failCount++;
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic emit(input logic [31:0] word);
		image[emitPtr] = word;
		emitPtr++;
	endtask

	// always two instructions, so code addresses stay predictable
	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		emit(uType(upper[31:12], rd, opLui));
		emit(iType(value[11:0], rd, 3'd0, rd, opImm));
	endtask

	task automatic expectSlot(input int slot, input logic [31:0] value);
		expSlot.push_back(slot);
		expWord.push_back(value);
	endtask

	task automatic storeAndExpect(input logic [4:0] rs, input logic [31:0] value);
		emit(sType(12'(slotPtr * 4), rs, 5'd31, 3'b010));
		expectSlot(slotPtr, value);
		slotPtr++;
	endtask

	task automatic startProgram();
		for (int i = 0; i < 1024; i++) begin
			image[i] = fillWord(i);
		end
		emitPtr = 0;
		slotPtr = 0;
		expSlot.delete();
		expWord.delete();
		loadConst(5'd31, 32'h800);
	endtask

	// done store, then spin on jal x0, 0
	task automatic endProgram();
		loadConst(5'd30, `DONE_ADDR);
		emit(sType(12'd0, 5'd0, 5'd30, 3'b010));
		emit(jType(21'd0, 5'd0));
	endtask

	task automatic checkResetFetch();
		checkEqual("memReq.valid", {31'd0, memReq.valid}, 32'd1);
		checkEqual("memReq.we", {31'd0, memReq.we}, 32'd0);
		checkEqual("memReq.addr", memReq.addr, `RESET_PC);
	endtask

	// image copies into memory on every reset edge
	task automatic resetCore();
		rstN = 1'b0;
		repeat (8) begin
			@(negedge clk);
			checkResetFetch();
		end
		rstN = 1'b1;
		checkResetFetch();
	endtask

	// log stores seen on the bus until the done store shows up
	task automatic runProgram();
		int cycles;
		logic done;
		resetCore();
		storeLog.delete();
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
			if (memReq.valid && memReq.we) begin
				storeLog.push_back(memReq.addr);
				done = (memReq.addr == `DONE_ADDR);
			end
		end
		if (!done) begin
			failRun("timeout: program never stored to the done address");
		end
		@(negedge clk);
	endtask

	task automatic verifySlots();
		for (int i = 0; i < expSlot.size(); i++) begin
			checkEqual($sformatf("mem[%h]", 32'h800 + 32'(expSlot[i] * 4)),
				mem[scratchWord + expSlot[i]], expWord[i]);
		end
	endtask

	task automatic testResetOrder();
		startProgram();
		emit(iType(12'h011, 5'd0, 3'd0, 5'd1, opImm));
		storeAndExpect(5'd1, 32'h11);
		emit(iType(12'h022, 5'd1, 3'd0, 5'd2, opImm));
		storeAndExpect(5'd2, 32'h33);
		emit(rType(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
		storeAndExpect(5'd3, 32'h22);
		endProgram();
		runProgram();
		checkEqual("store count", 32'(storeLog.size()), 32'd4);
		checkEqual("store 0 addr", storeLog[0], 32'h800);
		checkEqual("store 1 addr", storeLog[1], 32'h804);
		checkEqual("store 2 addr", storeLog[2], 32'h808);
		checkEqual("store 3 addr", storeLog[3], `DONE_ADDR);
		verifySlots();
	endtask

	task automatic testAluOps();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] bImm;
		logic [11:0] imm;
		logic [11:0] field;
		startProgram();
		for (int round = 0; round < 2; round++) begin
			a = $random(seed);
			b = $random(seed);
			// second round: negative a for SRA and signed/unsigned compares
			if (round == 1) begin
				a = a | 32'h8000_0000;
				b = b & 32'h7fff_ffff;
			end
			loadConst(5'd1, a);
			loadConst(5'd2, b);
			for (int f = 0; f < 8; f++) begin
				for (int alt = 0; alt < 2; alt++) begin
					if (alt == 0 || f == 0 || f == 5) begin
						emit(rType(alt == 1 ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
						storeAndExpect(5'd3, aluRef(3'(f), alt == 1, a, b));
					end
				end
			end
			imm = 12'($random(seed));
			for (int f = 0; f < 8; f++) begin
				for (int alt = 0; alt < 2; alt++) begin
					if (alt == 0 || f == 5) begin
						// shift immediates carry shamt and the modifier bit only
						if (f == 1 || f == 5) begin
							field = {alt == 1 ? 7'h20 : 7'h00, imm[4:0]};
							bImm = {27'd0, imm[4:0]};
						end else begin
							field = imm;
							bImm = {{20{imm[11]}}, imm};
						end
						emit(iType(field, 5'd1, 3'(f), 5'd4, opImm));
						storeAndExpect(5'd4, aluRef(3'(f), alt == 1, a, bImm));
					end
				end
			end
		end
		endProgram();
		runProgram();
		verifySlots();
	endtask

	task automatic testForwarding();
		logic [31:0] c;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		int s;
		startProgram();
		c = $random(seed);
		v2 = c + 32'd5;
		v3 = v2 + c;
		v4 = v3 - v2;
		v5 = v4 ^ v3;
		// dependent chain with no gaps
		loadConst(5'd1, c);
		emit(iType(12'd5, 5'd1, 3'd0, 5'd2, opImm));
		emit(rType(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
		emit(rType(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
		emit(rType(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
		// x0 written then read right away
		emit(rType(7'h00, 5'd4, 5'd5, 3'd0, 5'd0));
		emit(rType(7'h00, 5'd5, 5'd0, 3'd6, 5'd6));
		storeAndExpect(5'd2, v2);
		storeAndExpect(5'd3, v3);
		storeAndExpect(5'd4, v4);
		s = slotPtr;
		storeAndExpect(5'd5, v5);
		storeAndExpect(5'd6, v5);
		storeAndExpect(5'd0, 32'd0);
		// load then immediate use
		emit(iType(12'(s * 4), 5'd31, 3'b010, 5'd7, opLoad));
		emit(iType(12'd1, 5'd7, 3'd0, 5'd8, opImm));
		storeAndExpect(5'd8, v5 + 32'd1);
		emit(iType(12'(s * 4), 5'd31, 3'b010, 5'd0, opLoad));
		emit(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
		storeAndExpect(5'd9, 32'd0);
		endProgram();
		runProgram();
		verifySlots();
	endtask

	task automatic testControlFlow();
		int kinds[6];
		logic [31:0] vals[3];
		logic [31:0] marker;
		logic [31:0] p;
		logic taken;
		int s;
		kinds = '{0, 1, 4, 5, 6, 7};
		vals = '{32'hffff_fffb, 32'd3, 32'hffff_fffb};
		marker = $random(seed);
		startProgram();
		loadConst(5'd1, 32'hffff_fffb);
		loadConst(5'd2, 32'd3);
		loadConst(5'd9, marker);
		// operand pairs (x1,x1) (x1,x2) (x2,x1)
		for (int k = 0; k < 6; k++) begin
			for (int pr = 0; pr < 3; pr++) begin
				taken = branchRef(3'(kinds[k]), vals[pr == 2 ? 1 : 0],
					vals[pr == 0 ? 0 : (pr == 1 ? 1 : 0)]);
				emit(iType(12'd0, 5'd0, 3'd0, 5'd10, opImm));
				emit(bType(13'd12, pr == 2 ? 5'd2 : 5'd1, pr == 1 ? 5'd2 : 5'd1, 3'(kinds[k])));
				// the slot right after the branch must vanish when taken
				s = slotPtr;
				slotPtr++;
				emit(sType(12'(s * 4), 5'd9, 5'd31, 3'b010));
				expectSlot(s, taken ? fillWord(scratchWord + s) : marker);
				emit(iType(12'd1, 5'd0, 3'd0, 5'd10, opImm));
				storeAndExpect(5'd10, taken ? 32'd0 : 32'd1);
			end
		end
		p = 32'(emitPtr * 4);
		emit(jType(21'd8, 5'd5));
		s = slotPtr;
		slotPtr++;
		emit(sType(12'(s * 4), 5'd9, 5'd31, 3'b010));
		expectSlot(s, fillWord(scratchWord + s));
		storeAndExpect(5'd5, p + 32'd4);
		// jalr to an odd sum, lands on the even address below it
		p = 32'(emitPtr * 4) + 32'd8;
		loadConst(5'd6, p + 32'd8);
		emit(iType(12'd1, 5'd6, 3'd0, 5'd7, opJalr));
		s = slotPtr;
		slotPtr++;
		emit(sType(12'(s * 4), 5'd9, 5'd31, 3'b010));
		expectSlot(s, fillWord(scratchWord + s));
		// auipc at the landing spot exposes the pc the jump left behind
		emit(uType(20'd0, 5'd8, opAuipc));
		storeAndExpect(5'd8, p + 32'd8);
		storeAndExpect(5'd7, p + 32'd4);
		endProgram();
		runProgram();
		verifySlots();
	endtask

	task automatic testLoadStore();
		logic [31:0] bv;
		logic [31:0] w;
		logic [31:0] v;
		logic [31:0] exp;
		logic [7:0] byteVal;
		logic [15:0] halfVal;
		int s;
		startProgram();
		bv = $random(seed);
		loadConst(5'd2, bv);
		// narrow stores into fill words at every lane
		for (int lane = 0; lane < 4; lane++) begin
			s = slotPtr;
			slotPtr++;
			emit(sType(12'(s * 4 + lane), 5'd2, 5'd31, 3'b000));
			exp = fillWord(scratchWord + s);
			exp[8*lane +: 8] = bv[7:0];
			expectSlot(s, exp);
		end
		for (int lane = 0; lane < 4; lane += 2) begin
			s = slotPtr;
			slotPtr++;
			emit(sType(12'(s * 4 + lane), 5'd2, 5'd31, 3'b001));
			exp = fillWord(scratchWord + s);
			exp[8*lane +: 16] = bv[15:0];
			expectSlot(s, exp);
		end
		w = $random(seed);
		loadConst(5'd3, w);
		s = slotPtr;
		storeAndExpect(5'd3, w);
		emit(iType(12'(s * 4), 5'd31, 3'b010, 5'd4, opLoad));
		storeAndExpect(5'd4, w);
		// mixed-sign lanes for the extension checks
		v = 32'h80f1_7f82;
		loadConst(5'd5, v);
		s = slotPtr;
		storeAndExpect(5'd5, v);
		for (int lane = 0; lane < 4; lane++) begin
			byteVal = v[8*lane +: 8];
			emit(iType(12'(s * 4 + lane), 5'd31, 3'b000, 5'd6, opLoad));
			storeAndExpect(5'd6, {{24{byteVal[7]}}, byteVal});
			emit(iType(12'(s * 4 + lane), 5'd31, 3'b100, 5'd7, opLoad));
			storeAndExpect(5'd7, {24'd0, byteVal});
		end
		for (int lane = 0; lane < 4; lane += 2) begin
			halfVal = v[8*lane +: 16];
			emit(iType(12'(s * 4 + lane), 5'd31, 3'b001, 5'd6, opLoad));
			storeAndExpect(5'd6, {{16{halfVal[15]}}, halfVal});
			emit(iType(12'(s * 4 + lane), 5'd31, 3'b101, 5'd7, opLoad));
			storeAndExpect(5'd7, {16'd0, halfVal});
		end
		endProgram();
		runProgram();
		verifySlots();
	endtask

	task automatic testUpperImm();
		logic [31:0] r;
		logic [19:0] u1;
		logic [19:0] u2;
		logic [31:0] p;
		startProgram();
		r = $random(seed);
		u1 = r[19:0];
		r = $random(seed);
		// negative upper immediate for AUIPC
		u2 = r[19:0] | 20'h80000;
		emit(uType(u1, 5'd1, opLui));
		storeAndExpect(5'd1, {u1, 12'h000});
		p = 32'(emitPtr * 4);
		emit(uType(u2, 5'd2, opAuipc));
		storeAndExpect(5'd2, p + {u2, 12'h000});
		endProgram();
		runProgram();
		verifySlots();
	endtask

	initial begin
		rstN = 1'b0;
		seed = 32'h63c7873b;
		failCount = 0;
		testResetOrder();
		testAluOps();
		testForwarding();
		testControlFlow();
		testLoadStore();
		testUpperImm();
		if (failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
